// File: Bender.yml
package:
  name: periph_bus

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/periph_bus_pkg.sv
      - verilog/apb_node.sv
      - verilog/apb_reg_periph.sv
      - verilog/apb_timer_periph.sv
      - verilog/periph_bus_wrap.sv
  - target: simulation
    files:
      - testbench/periph_bus_tb.sv

// File: periph_bus_wrap.f
+incdir+verilog
verilog/periph_bus_pkg.sv
verilog/apb_node.sv
verilog/apb_reg_periph.sv
verilog/apb_timer_periph.sv
verilog/periph_bus_wrap.sv
testbench/periph_bus_tb.sv

// File: testbench/periph_bus_patterns.txt
# columns are op addr wdata exp_data exp_err in hex
# op letters mean w write, r read, g gpio_out level, t event period, q quiet cycles
w 1A104000 C0DE0000 0 0
w 1A104004 C0DE0011 0 0
w 1A104008 C0DE0022 0 0
w 1A10400C C0DE0033 0 0
w 1A104010 C0DE0044 0 0
w 1A104014 C0DE0055 0 0
w 1A104018 C0DE0066 0 0
w 1A10401C C0DE0077 0 0
w 1A101000 A5A50F0F 0 0
g 0 0 A5A50F0F 0
w 1A101004 5A5AF0F0 0 0
r 1A104000 0 C0DE0000 0
r 1A104004 0 C0DE0011 0
r 1A104008 0 C0DE0022 0
r 1A10400C 0 C0DE0033 0
r 1A104010 0 C0DE0044 0
r 1A104014 0 C0DE0055 0
r 1A104018 0 C0DE0066 0
r 1A10401C 0 C0DE0077 0
r 1A101000 0 A5A50F0F 0
r 1A101004 0 5A5AF0F0 0
r 1A101008 0 0 0
r 1A104024 0 0 1
r 1A103000 0 0 1
w 1A10B004 5 0 0
w 1A10B000 1 0 0
t 0 0 6 0
w 1A10B000 0 0 0
q 0 0 18 0

// File: testbench/periph_bus_tb.sv
// testbench for the peripheral bus
// clock and reset, APB driver tasks, pattern file reader,
// compare tasks, timer event monitor and watchdog

`timescale 1ns/1ps
`default_nettype none

`include "periph_bus_consts.svh"

module periph_bus_tb;

    import periph_bus_pkg::*;

    logic                       clk_i;
    logic                       rst;
    apb_req_t                   apb_req;
    apb_rsp_t                   apb_rsp;
    logic [`APB_DATA_WIDTH-1:0] gpio_out;
    logic                       timer_event;

    // one entry per transaction line of the pattern file
    byte unsigned op_q [$];
    logic [31:0]  addr_q [$];
    logic [31:0]  wdata_q [$];
    logic [31:0]  exp_q [$];
    logic [31:0]  err_q [$];

    int           watchdog_cycles = 0;
    int           cycle_cnt = 0;
    int           last_event_cycle = 0;
    int           event_period = 0;
    int           event_count = 0;
    logic [31:0]  rand_state = 32'h58d3_0685;

    periph_bus_wrap DUT (
        .clk_i       ( clk_i       ),
        .rst         ( rst         ),
        .apb_req     ( apb_req     ),
        .apb_rsp     ( apb_rsp     ),
        .gpio_out    ( gpio_out    ),
        .timer_event ( timer_event )
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // outputs are sampled on the falling edge, half a period after they settle
    always @(negedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timer_event) begin
            event_period     <= cycle_cnt - last_event_cycle;
            last_event_cycle <= cycle_cnt;
            event_count      <= event_count + 1;
        end
    end

    // **************************************************
    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_on_failure();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_rsp(input string name, input apb_rsp_t expected, input apb_rsp_t actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_gpio(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_event_period(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("mismatch %s expected %0d actual %0d", name, expected, actual);
            stop_on_failure();
        end
    endtask

    // setup phase, then access phase held until pready is seen
    task automatic run_transfer(input logic write, input logic [31:0] addr,
                                input logic [31:0] wdata, output apb_rsp_t rsp);
        @(posedge clk_i);
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        apb_req.pwrite  <= write;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        @(posedge clk_i);
        apb_req.penable <= 1'b1;
        @(negedge clk_i);
        while (!apb_rsp.pready) @(negedge clk_i);
        rsp = apb_rsp;
        // the next rising edge completes the transfer
        @(posedge clk_i);
        apb_req <= '0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] wdata);
        apb_rsp_t rsp;
        run_transfer(1'b1, addr, wdata, rsp);
    endtask

    task automatic apb_read(input logic [31:0] addr, output apb_rsp_t rsp);
        run_transfer(1'b0, addr, 32'h0, rsp);
    endtask

    task automatic load_patterns();
        int           fd;
        int           n;
        string        line;
        byte unsigned op;
        logic [31:0]  addr;
        logic [31:0]  wdata;
        logic [31:0]  exp_data;
        logic [31:0]  exp_err;
        fd = $fopen("testbench/periph_bus_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file testbench/periph_bus_patterns.txt");
            stop_on_failure();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 2 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%c %h %h %h %h", op, addr, wdata, exp_data, exp_err);
            if (n != 5) begin
                $display("pattern line has %0d fields instead of 5: %s", n, line);
                stop_on_failure();
            end
            op_q.push_back(op);
            addr_q.push_back(addr);
            wdata_q.push_back(wdata);
            exp_q.push_back(exp_data);
            err_q.push_back(exp_err);
        end
        $fclose(fd);
    endtask

    // **************************************************
    initial begin : main_seq
        apb_rsp_t rsp;
        apb_rsp_t expected;
        string    name;
        int       n0;
        rst     = 1'b1;
        apb_req = '0;
        load_patterns();
        watchdog_cycles = op_q.size() * 20 + 200;
        repeat (2) @(posedge clk_i);
        rst <= 1'b0;
        foreach (op_q[i]) begin
            // idle gap between transactions, results must not depend on it
            rand_state = next_random(rand_state);
            repeat (rand_state[17:16]) @(posedge clk_i);
            name = $sformatf("line %0d op %c addr %h", i, op_q[i], addr_q[i]);
            case (op_q[i])
                "w": apb_write(addr_q[i], wdata_q[i]);
                "r": begin
                    apb_read(addr_q[i], rsp);
                    expected.prdata  = exp_q[i];
                    expected.pready  = 1'b1;
                    expected.pslverr = err_q[i][0];
                    check_rsp(name, expected, rsp);
                end
                "g": begin
                    @(negedge clk_i);
                    check_gpio(name, exp_q[i], gpio_out);
                end
                "t": begin
                    // two fresh pulses so the measured distance lies fully inside this step
                    n0 = event_count;
                    while (event_count < n0 + 2) @(negedge clk_i);
                    check_event_period(name, exp_q[i], event_period);
                end
                "q": begin
                    n0 = event_count;
                    repeat (exp_q[i]) @(negedge clk_i);
                    if (event_count != n0) begin
                        $display("timer_event pulsed after the timer was disabled in %s", name);
                        stop_on_failure();
                    end
                end
                default: begin
                    $display("unknown operation in pattern %s", name);
                    stop_on_failure();
                end
            endcase
        end
        $display("Test passed");
        $finish;
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk_i);
        $display("watchdog expired after %0d cycles, the bus hung", watchdog_cycles);
        stop_on_failure();
    end

endmodule

`default_nettype wire

// File: verilog/apb_node.sv
// APB node
// range decode of paddr, psel fan-out, response multiplexing
// and the error answer for addresses outside every range

`timescale 1ns/1ps
`default_nettype none

`include "periph_bus_consts.svh"

module apb_node #(
    parameter int NB_SLAVE = `NB_SLAVE
) (
    input  logic                                         clk_i,
    input  logic                                         rst,
    input  periph_bus_pkg::apb_req_t                     slv_req,
    output periph_bus_pkg::apb_rsp_t                     slv_rsp,
    output periph_bus_pkg::apb_req_t                     mst_req [NB_SLAVE],
    input  periph_bus_pkg::apb_rsp_t                     mst_rsp [NB_SLAVE],
    input  logic [NB_SLAVE-1:0][`APB_ADDR_WIDTH-1:0]     start_addr,
    input  logic [NB_SLAVE-1:0][`APB_ADDR_WIDTH-1:0]     end_addr
);

    import periph_bus_pkg::*;

    logic [NB_SLAVE-1:0] dec;
    logic [NB_SLAVE-1:0] sel;
    logic [NB_SLAVE-1:0] sel_q;
    logic                busy_q;
    logic                access;

    assign access = slv_req.psel && slv_req.penable;

    // one bit per slave whose range holds paddr
    always_comb begin
        for (int i = 0; i < NB_SLAVE; i++) begin
            dec[i] = (slv_req.paddr >= start_addr[i]) && (slv_req.paddr <= end_addr[i]);
        end
    end

    // selection captured in setup is held until the transfer completes
    always_ff @(posedge clk_i) begin
        if (rst) begin
            busy_q <= 1'b0;
            sel_q  <= '0;
        end else if (access && slv_rsp.pready) begin
            busy_q <= 1'b0;
        end else if (slv_req.psel && !busy_q) begin
            busy_q <= 1'b1;
            sel_q  <= dec;
        end
    end

    assign sel = busy_q ? sel_q : dec;

    // ************************************************
    // only psel is steered, the rest goes to every slave
    always_comb begin
        for (int i = 0; i < NB_SLAVE; i++) begin
            mst_req[i]      = slv_req;
            mst_req[i].psel = slv_req.psel && sel[i];
        end
    end

    always_comb begin
        slv_rsp = '0;
        if (|sel) begin
            for (int i = 0; i < NB_SLAVE; i++) begin
                if (sel[i]) slv_rsp = mst_rsp[i];
            end
        end else if (access) begin
            // nobody owns this address, so the node completes it with an error
            slv_rsp.pready  = 1'b1;
            slv_rsp.pslverr = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/apb_reg_periph.sv
// APB register bank
// NUM_REGS words selected by word offset, WAIT_STATES extra access cycles,
// register 0 also driven out as a level

`timescale 1ns/1ps
`default_nettype none

`include "periph_bus_consts.svh"

module apb_reg_periph #(
    parameter int NUM_REGS    = 4,
    parameter int WAIT_STATES = 0
) (
    input  logic                            clk_i,
    input  logic                            rst,
    input  periph_bus_pkg::apb_req_t        req,
    output periph_bus_pkg::apb_rsp_t        rsp,
    output logic [`APB_DATA_WIDTH-1:0]      reg0
);

    import periph_bus_pkg::*;

    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
    localparam int IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

    logic [NUM_REGS-1:0][`APB_DATA_WIDTH-1:0] regs_q;
    logic [CNT_W-1:0]                         wait_q;
    logic [`REG_OFFSET_MSB-`REG_OFFSET_LSB:0] word;
    logic                                     access;
    logic                                     ready;
    logic                                     in_range;

    assign access   = req.psel && req.penable;
    assign ready    = access && (wait_q == CNT_W'(WAIT_STATES));
    assign word     = req.paddr[`REG_OFFSET_MSB:`REG_OFFSET_LSB];
    assign in_range = word < NUM_REGS;

    // counts access cycles until the bank is ready
    always_ff @(posedge clk_i) begin
        if (rst) wait_q <= '0;
        else if (access && !ready) wait_q <= wait_q + 1'b1;
        else wait_q <= '0;
    end

    // a write lands on the completing edge
    always_ff @(posedge clk_i) begin
        if (rst) begin
            regs_q <= '0;
        end else if (ready && req.pwrite && in_range) begin
            regs_q[word[IDX_W-1:0]] <= req.pwdata;
        end
    end

    assign rsp.pready  = ready;
    assign rsp.pslverr = ready && !in_range;
    assign rsp.prdata  = (ready && !req.pwrite && in_range) ? regs_q[word[IDX_W-1:0]] : '0;

    assign reg0 = regs_q[0];

endmodule

`default_nettype wire

// File: verilog/apb_timer_periph.sv
// APB timer
// ctrl (bit 0 enables counting), compare and a readable count,
// one-cycle event pulse when the count reaches compare

`timescale 1ns/1ps
`default_nettype none

`include "periph_bus_consts.svh"

module apb_timer_periph (
    input  logic                        clk_i,
    input  logic                        rst,
    input  periph_bus_pkg::apb_req_t    req,
    output periph_bus_pkg::apb_rsp_t    rsp,
    output logic                        event_o
);

    import periph_bus_pkg::*;

    logic                       enable_q;
    logic [`APB_DATA_WIDTH-1:0] compare_q;
    logic [`APB_DATA_WIDTH-1:0] count_q;
    timer_reg_e                 reg_sel;
    logic                       access;
    logic                       wr;
    logic                       match;

    assign access  = req.psel && req.penable;
    assign wr      = access && req.pwrite;
    assign reg_sel = timer_reg_e'(req.paddr[`REG_OFFSET_MSB:`REG_OFFSET_LSB]);
    assign match   = enable_q && (count_q == compare_q);

    always_ff @(posedge clk_i) begin
        if (rst) begin
            enable_q  <= 1'b0;
            compare_q <= '0;
        end else if (wr) begin
            if (reg_sel == TIMER_CTRL) enable_q <= req.pwdata[0];
            if (reg_sel == TIMER_CMP) compare_q <= req.pwdata;
        end
    end

    // ************************************************
    // counter wraps to zero on the edge after a match
    always_ff @(posedge clk_i) begin
        if (rst) count_q <= '0;
        else if (wr && reg_sel == TIMER_COUNT) count_q <= '0;
        else if (match) count_q <= '0;
        else if (enable_q) count_q <= count_q + 1'b1;
    end

    assign event_o = match;

    // zero wait states, unknown offsets answer with an error
    always_comb begin
        rsp        = '0;
        rsp.pready = access;
        if (access) begin
            case (reg_sel)
                TIMER_CTRL:  rsp.prdata = {{(`APB_DATA_WIDTH-1){1'b0}}, enable_q};
                TIMER_CMP:   rsp.prdata = compare_q;
                TIMER_COUNT: rsp.prdata = count_q;
                default:     rsp.pslverr = 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/periph_bus_consts.svh
// peripheral bus constants
// slave count, APB widths, address map ranges, register counts and wait states
// ranges of peripherals not present in this bus are kept as reserved

`ifndef PERIPH_BUS_CONSTS_SVH
`define PERIPH_BUS_CONSTS_SVH

`define NB_SLAVE            3
`define APB_ADDR_WIDTH      32
`define APB_DATA_WIDTH      32

// registers are addressed by word offset inside each 4 KiB window
`define REG_OFFSET_MSB      11
`define REG_OFFSET_LSB      2

// ************************************************
// decoded ranges, inclusive on both ends
`define SOC_CTRL_START_ADDR 32'h1A10_4000
`define SOC_CTRL_END_ADDR   32'h1A10_4FFF
`define GPIO_START_ADDR     32'h1A10_1000
`define GPIO_END_ADDR       32'h1A10_1FFF
`define TIMER_START_ADDR    32'h1A10_B000
`define TIMER_END_ADDR      32'h1A10_BFFF

// reserved ranges, not decoded by this node
`define CLK_CTRL_START_ADDR 32'h1A10_0000
`define CLK_CTRL_END_ADDR   32'h1A10_0FFF
`define UDMA_START_ADDR     32'h1A10_2000
`define UDMA_END_ADDR       32'h1A10_3FFF

// ************************************************
`define SOC_CTRL_NUM_REGS   8
`define SOC_CTRL_WAIT       2
`define GPIO_NUM_REGS       4
`define GPIO_WAIT           0

`endif

// File: verilog/periph_bus_pkg.sv
// peripheral bus types
// APB request and response structs, timer register offsets

`default_nettype none

`include "periph_bus_consts.svh"

package periph_bus_pkg;

    // requester side of one APB port
    typedef struct packed {
        logic [`APB_ADDR_WIDTH-1:0] paddr;
        logic [`APB_DATA_WIDTH-1:0] pwdata;
        logic                       pwrite;
        logic                       psel;
        logic                       penable;
    } apb_req_t;

    // completer side of one APB port
    typedef struct packed {
        logic [`APB_DATA_WIDTH-1:0] prdata;
        logic                       pready;
        logic                       pslverr;
    } apb_rsp_t;

    // word offsets inside the timer window
    typedef enum logic [`REG_OFFSET_MSB-`REG_OFFSET_LSB:0] {
        TIMER_CTRL  = 10'd0,
        TIMER_CMP   = 10'd1,
        TIMER_COUNT = 10'd2
    } timer_reg_e;

endpackage

`default_nettype wire

// File: verilog/periph_bus_wrap.sv
// peripheral bus top level
// APB node with the address table, control bank, GPIO bank and timer

`timescale 1ns/1ps
`default_nettype none

`include "periph_bus_consts.svh"

module periph_bus_wrap (
    input  logic                        clk_i,
    input  logic                        rst,
    input  periph_bus_pkg::apb_req_t    apb_req,
    output periph_bus_pkg::apb_rsp_t    apb_rsp,
    output logic [`APB_DATA_WIDTH-1:0]  gpio_out,
    output logic                        timer_event
);

    import periph_bus_pkg::*;

    localparam int NB_SLAVE = `NB_SLAVE;

    logic [NB_SLAVE-1:0][`APB_ADDR_WIDTH-1:0] s_start_addr;
    logic [NB_SLAVE-1:0][`APB_ADDR_WIDTH-1:0] s_end_addr;
    apb_req_t                                 s_req [NB_SLAVE];
    apb_rsp_t                                 s_rsp [NB_SLAVE];

    // slot 0 control bank, slot 1 GPIO, slot 2 timer
    assign s_start_addr[0] = `SOC_CTRL_START_ADDR;
    assign s_end_addr[0]   = `SOC_CTRL_END_ADDR;
    assign s_start_addr[1] = `GPIO_START_ADDR;
    assign s_end_addr[1]   = `GPIO_END_ADDR;
    assign s_start_addr[2] = `TIMER_START_ADDR;
    assign s_end_addr[2]   = `TIMER_END_ADDR;

    // ************************************************
    apb_node #(.NB_SLAVE(NB_SLAVE)) apb_node_i (
        .clk_i      ( clk_i        ),
        .rst        ( rst          ),
        .slv_req    ( apb_req      ),
        .slv_rsp    ( apb_rsp      ),
        .mst_req    ( s_req        ),
        .mst_rsp    ( s_rsp        ),
        .start_addr ( s_start_addr ),
        .end_addr   ( s_end_addr   )
    );

    // the control bank's register 0 level has no pin on this top level
    apb_reg_periph #(.NUM_REGS(`SOC_CTRL_NUM_REGS), .WAIT_STATES(`SOC_CTRL_WAIT)) soc_ctrl_i (
        .clk_i(clk_i), .rst(rst), .req(s_req[0]), .rsp(s_rsp[0]), .reg0()
    );

    apb_reg_periph #(.NUM_REGS(`GPIO_NUM_REGS), .WAIT_STATES(`GPIO_WAIT)) gpio_i (
        .clk_i(clk_i), .rst(rst), .req(s_req[1]), .rsp(s_rsp[1]), .reg0(gpio_out)
    );

    apb_timer_periph timer_i (
        .clk_i(clk_i), .rst(rst), .req(s_req[2]), .rsp(s_rsp[2]), .event_o(timer_event)
    );

endmodule

`default_nettype wire
